/* mmio_port_top.f */
hw/mmio_pkg.sv
hw/mmio_req_router.sv
hw/null_func.sv
hw/cpl_arbiter.sv
hw/mmio_port_top.sv
sim/tb_mmio_port.sv

/* sim/tb_mmio_port.sv */
`timescale 1ns/100ps

module tb_mmio_port;
   import mmio_pkg::*;

   localparam int NUM_REQ        = 70;   // Requests over all phases
   localparam int TIMEOUT_CYCLES = 40 * NUM_REQ + 200;

   logic          clk;
   logic          rst_n;
   mmio_req_t     i_req;
   logic          i_req_valid;
   logic          o_req_ready;
   mmio_cpl_t     o_cpl;
   logic          o_cpl_valid;
   logic          i_cpl_ready;

   // Scoreboard, one entry per tag
   logic [255:0]  exp_pending;
   cpl_status_t   exp_status [256];
   logic [1:0]    exp_len [256];
   csr_data_t     exp_data [256];
   mmio_req_t     issued [256];   // Read request behind each tag
   cpl_status_t   exp_status_now;
   logic [1:0]    exp_len_now;
   csr_data_t     exp_data_now;
   mmio_req_t     issued_now;
   int            outstanding;
   csr_data_t     scratch_m [NUM_FUNCS];   // Model of each function
   logic [31:0]   debug_m [NUM_FUNCS];
   tag_t          next_tag;
   logic [31:0]   ready_rng;
   logic [31:0]   stim_rng;
   logic          random_ready;
   logic          ready_low_seen;
   int            cycle_cnt;
   logic          cpl_fire;
   logic          exp_hit;

   mmio_port_top DUT (
      .clk (clk), .rst_n (rst_n),
      .i_req (i_req), .i_req_valid (i_req_valid), .o_req_ready (o_req_ready),
      .o_cpl (o_cpl), .o_cpl_valid (o_cpl_valid), .i_cpl_ready (i_cpl_ready)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_stim();
      stim_rng = xorshift32(stim_rng);
      return stim_rng;
   endfunction

   task automatic stop_failed();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] got);
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
      stop_failed();
   endtask

   task automatic abort_run(input string why);
      $display("%0t: %s", $time, why);
      stop_failed();
   endtask

   // ------------------------------
   // Register model
   // ------------------------------
   function automatic csr_data_t model_read(input mmio_req_t r);
      csr_data_t full;
      case (r.addr[11:3])
         DFH_ADDR[11:3]:     full = DFH_VALUE;
         GUID_L_ADDR[11:3]:  full = (r.fn == 0) ? VIRTIO_GUID_L : NULL_GUID_L;
         GUID_H_ADDR[11:3]:  full = (r.fn == 0) ? VIRTIO_GUID_H : NULL_GUID_H;
         SCRATCH_ADDR[11:3]: full = scratch_m[r.fn[0]];
         default:            full = {debug_m[r.fn[0]], 20'h0, r.addr};
      endcase
      if (r.len2)
         return full;
      return r.addr[2] ? {32'h0, full[63:32]} : {32'h0, full[31:0]};
   endfunction

   function automatic void model_write(input mmio_req_t r);
      if (r.fn < NUM_FUNCS && r.addr[11:3] == SCRATCH_ADDR[11:3]) begin
         if (r.len2)
            scratch_m[r.fn[0]] = r.data;
         else if (r.addr[2])
            scratch_m[r.fn[0]][63:32] = r.data[31:0];
         else
            scratch_m[r.fn[0]][31:0] = r.data[31:0];
      end else if (r.fn < NUM_FUNCS && r.addr[11:3] > SCRATCH_ADDR[11:3]) begin
         debug_m[r.fn[0]] = DEBUG_STRAY;   // Past the scratchpad nothing is mapped
      end
   endfunction

   task automatic send_req(input logic wr, input fn_t f, input addr_t a, input logic len2,
                           input csr_data_t d);
      mmio_req_t r;
      logic      accepted;
      r = '{wr: wr, fn: f, tag: next_tag, req_id: {8'h5a, 6'h0, f}, addr: a, len2: len2,
            data: d};
      if (exp_pending[next_tag]) begin
         abort_run("a tag was reused while its read was still outstanding");
      end else begin
         next_tag = next_tag + 1'b1;
         if (wr) begin
            model_write(r);
         end else begin
            exp_pending[r.tag] = 1'b1;
            issued[r.tag]      = r;
            exp_len[r.tag]     = len2 ? 2'd2 : 2'd1;
            exp_status[r.tag]  = (f < NUM_FUNCS) ? CPL_SC : CPL_UR;
            exp_data[r.tag]    = (f < NUM_FUNCS) ? model_read(r) : '0;
            outstanding++;
         end
         i_req       = r;
         i_req_valid = 1'b1;
         do begin
            @(negedge clk);   // Ready is settled mid cycle
            accepted = o_req_ready;
            if (!accepted && o_cpl_valid && !i_cpl_ready)
               ready_low_seen = 1'b1;
            @(posedge clk);
         end while (!accepted);
         #10;
         i_req_valid = 1'b0;
      end
   endtask

   task automatic idle(input int n);
      if (n > 0) begin
         repeat (n) @(posedge clk);
         #10;
      end
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (outstanding != 0 && waited < 200) begin
         @(negedge clk);
         waited++;
      end
      @(posedge clk);
      #10;
   endtask

   // ------------------------------
   // Completion checks
   // ------------------------------
   assign cpl_fire       = o_cpl_valid & i_cpl_ready;
   assign exp_hit        = exp_pending[o_cpl.tag];
   assign exp_status_now = exp_status[o_cpl.tag];
   assign exp_len_now    = exp_len[o_cpl.tag];
   assign exp_data_now   = exp_data[o_cpl.tag];
   assign issued_now     = issued[o_cpl.tag];

   always @(posedge clk) begin
      if (rst_n && cpl_fire) begin
         exp_pending[o_cpl.tag] = 1'b0;   // Retire the tag
         outstanding--;
      end
   end

   a_cpl_known: assert property (@(posedge clk) disable iff (!rst_n) cpl_fire |-> exp_hit)
      else abort_run($sformatf("completion for tag %h was not expected", $sampled(o_cpl.tag)));
   a_cpl_status: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_fire |-> o_cpl.status == exp_status_now)
      else report_mismatch("o_cpl.status", $sampled(exp_status_now), $sampled(o_cpl.status));
   a_cpl_len: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_fire |-> o_cpl.len == exp_len_now)
      else report_mismatch("o_cpl.len", $sampled(exp_len_now), $sampled(o_cpl.len));
   a_cpl_data: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_fire |-> o_cpl.data == exp_data_now)
      else report_mismatch("o_cpl.data", $sampled(exp_data_now), $sampled(o_cpl.data));
   a_cpl_fn: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_fire |-> o_cpl.fn == issued_now.fn)
      else report_mismatch("o_cpl.fn", $sampled(issued_now.fn), $sampled(o_cpl.fn));
   a_cpl_req_id: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_fire |-> o_cpl.req_id == issued_now.req_id)
      else report_mismatch("o_cpl.req_id", $sampled(issued_now.req_id),
                           $sampled(o_cpl.req_id));
   a_cpl_low_addr: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_fire |-> o_cpl.low_addr == issued_now.addr[6:0])
      else report_mismatch("o_cpl.low_addr", $sampled(issued_now.addr[6:0]),
                           $sampled(o_cpl.low_addr));
   a_cpl_steady: assert property (@(posedge clk) disable iff (!rst_n)
      o_cpl_valid && !i_cpl_ready |=> o_cpl_valid && $stable(o_cpl))
      else abort_run("o_cpl changed while the completion was stalled");

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      if (cycle_cnt >= TIMEOUT_CYCLES)
         abort_run("timeout, the run did not reach its end");
      else
         cycle_cnt++;
   end

   always @(posedge clk) begin
      #10;
      if (random_ready) begin
         ready_rng   = xorshift32(ready_rng);
         i_cpl_ready = ready_rng[0];
      end else begin
         i_cpl_ready = 1'b1;
      end
   end

   initial begin
      logic [31:0] rnd;
      rst_n          = 1'b0;
      i_req          = '0;
      i_req_valid    = 1'b0;
      i_cpl_ready    = 1'b1;
      exp_pending    = '0;
      outstanding    = 0;
      next_tag       = '0;
      ready_rng      = 32'h386d;
      stim_rng       = xorshift32(32'h386d);
      random_ready   = 1'b0;
      ready_low_seen = 1'b0;
      cycle_cnt      = 0;
      scratch_m      = '{default: '0};
      debug_m        = '{default: DEBUG_RESET};
      repeat (10) @(posedge clk);
      #10;
      rst_n = 1'b1;
      @(posedge clk);
      #10;
      assert (o_cpl_valid == 1'b0) else report_mismatch("o_cpl_valid", 0, o_cpl_valid);
      assert (o_req_ready == 1'b1) else report_mismatch("o_req_ready", 1, o_req_ready);

      // Idle bus, completion on the third edge after the transfer
      send_req(1'b0, 2'd0, DFH_ADDR, 1'b1, '0);
      repeat (2) @(posedge clk);
      #10;
      assert (o_cpl_valid == 1'b0) else report_mismatch("o_cpl_valid", 0, o_cpl_valid);
      @(posedge clk);
      #10;
      assert (o_cpl_valid == 1'b1) else report_mismatch("o_cpl_valid", 1, o_cpl_valid);
      drain();

      // DFH, GUID_L, GUID_H as 2-dword, low and high dword
      for (int f = 0; f < NUM_FUNCS; f++) begin
         for (int k = 0; k < 3; k++) begin
            send_req(1'b0, fn_t'(f), addr_t'(8 * k), 1'b1, '0);
            send_req(1'b0, fn_t'(f), addr_t'(8 * k), 1'b0, '0);
            send_req(1'b0, fn_t'(f), addr_t'(8 * k + 4), 1'b0, '0);
         end
      end
      drain();

      // ------------------------------
      // Scratchpad
      // ------------------------------
      for (int f = 0; f < NUM_FUNCS; f++)
         send_req(1'b1, fn_t'(f), SCRATCH_ADDR, 1'b1, {next_stim(), next_stim()});
      for (int f = 0; f < NUM_FUNCS; f++) begin
         send_req(1'b0, fn_t'(f), SCRATCH_ADDR, 1'b1, '0);
         send_req(1'b0, fn_t'(f), SCRATCH_ADDR, 1'b0, '0);
         send_req(1'b0, fn_t'(f), SCRATCH_ADDR + 12'h4, 1'b0, '0);
      end
      for (int f = 0; f < NUM_FUNCS; f++) begin
         send_req(1'b1, fn_t'(f), SCRATCH_ADDR, 1'b0, {next_stim(), next_stim()});
         send_req(1'b1, fn_t'(f), SCRATCH_ADDR + 12'h4, 1'b0, {next_stim(), next_stim()});
      end
      for (int f = 0; f < NUM_FUNCS; f++)
         send_req(1'b0, fn_t'(f), SCRATCH_ADDR, 1'b1, '0);
      drain();

      // Unmapped offsets, stray write on one function at a time
      send_req(1'b0, 2'd0, 12'h100, 1'b1, '0);
      send_req(1'b0, 2'd1, 12'h100, 1'b1, '0);
      send_req(1'b1, 2'd0, 12'h200, 1'b0, '1);
      send_req(1'b0, 2'd0, 12'h100, 1'b1, '0);
      send_req(1'b0, 2'd1, 12'h100, 1'b1, '0);
      send_req(1'b1, 2'd1, 12'h7f8, 1'b1, '1);
      send_req(1'b0, 2'd1, 12'h104, 1'b0, '0);
      drain();

      // Functions 2 and 3
      send_req(1'b0, 2'd2, GUID_L_ADDR, 1'b1, '0);
      send_req(1'b0, 2'd3, SCRATCH_ADDR, 1'b0, '0);
      send_req(1'b1, 2'd2, SCRATCH_ADDR, 1'b1, '1);
      send_req(1'b1, 2'd3, SCRATCH_ADDR + 12'h4, 1'b0, '1);
      send_req(1'b0, 2'd0, SCRATCH_ADDR, 1'b1, '0);
      send_req(1'b0, 2'd1, SCRATCH_ADDR, 1'b1, '0);
      drain();

      // ------------------------------
      // Back-pressure, mixed targets
      // ------------------------------
      random_ready   = 1'b1;
      ready_low_seen = 1'b0;
      for (int n = 0; n < 24; n++) begin
         rnd = next_stim();
         send_req(1'b0, fn_t'(rnd[9:8] % 3), {7'h0, rnd[5:4], rnd[6], 2'b00}, rnd[7], '0);
         idle((rnd[13:12] == 2'b11) ? 2 : 0);   // Mostly back to back
      end
      drain();
      random_ready = 1'b0;
      assert (ready_low_seen)
         else abort_run("o_req_ready never dropped while completions were stalled");

      if (outstanding != 0 || exp_pending != '0) begin
         abort_run($sformatf("%0d completions are missing at the end", outstanding));
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

/* hw/mmio_port_top.sv */
`timescale 1ns/100ps

module mmio_port_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mmio_pkg::mmio_req_t  i_req,
   input  logic                 i_req_valid,
   output logic                 o_req_ready,
   output mmio_pkg::mmio_cpl_t  o_cpl,
   output logic                 o_cpl_valid,
   input  logic                 i_cpl_ready
);
   import mmio_pkg::*;

   mmio_req_t               func_req;
   logic [NUM_FUNCS-1:0]    func_deliver;
   logic [NUM_FUNCS-1:0]    func_free;
   mmio_cpl_t               src_cpl [NUM_CPL_SRC];
   logic [NUM_CPL_SRC-1:0]  src_valid;
   logic [NUM_CPL_SRC-1:0]  src_taken;

   mmio_req_router u_router (
      .clk (clk), .rst_n (rst_n),
      .i_req (i_req), .i_req_valid (i_req_valid), .o_req_ready (o_req_ready),
      .i_func_free (func_free), .o_func_req (func_req), .o_func_deliver (func_deliver),
      .o_ur_cpl (src_cpl[UR_SRC]), .o_ur_valid (src_valid[UR_SRC]),
      .i_ur_taken (src_taken[UR_SRC])
   );

   // Function 0 reports virtio, function 1 the null GUID
   null_func #(.USE_VIRTIO_GUID (1)) u_func0 (
      .clk (clk), .rst_n (rst_n),
      .i_req (func_req), .i_deliver (func_deliver[0]), .o_free (func_free[0]),
      .o_cpl (src_cpl[0]), .o_cpl_valid (src_valid[0]), .i_cpl_taken (src_taken[0])
   );

   null_func #(.USE_VIRTIO_GUID (0)) u_func1 (
      .clk (clk), .rst_n (rst_n),
      .i_req (func_req), .i_deliver (func_deliver[1]), .o_free (func_free[1]),
      .o_cpl (src_cpl[1]), .o_cpl_valid (src_valid[1]), .i_cpl_taken (src_taken[1])
   );

   cpl_arbiter u_arb (
      .clk (clk), .rst_n (rst_n),
      .i_src_cpl (src_cpl), .i_src_valid (src_valid), .o_src_taken (src_taken),
      .o_cpl (o_cpl), .o_cpl_valid (o_cpl_valid), .i_cpl_ready (i_cpl_ready)
   );

endmodule

/* hw/cpl_arbiter.sv */
`timescale 1ns/100ps

module cpl_arbiter (
   input  logic                              clk,
   input  logic                              rst_n,
   input  mmio_pkg::mmio_cpl_t               i_src_cpl [mmio_pkg::NUM_CPL_SRC],
   input  logic [mmio_pkg::NUM_CPL_SRC-1:0]  i_src_valid,
   output logic [mmio_pkg::NUM_CPL_SRC-1:0]  o_src_taken,
   output mmio_pkg::mmio_cpl_t               o_cpl,
   output logic                              o_cpl_valid,
   input  logic                              i_cpl_ready
);
   import mmio_pkg::*;

   logic [SRC_IDX_W-1:0]  ptr_q;       // Last winner
   logic [SRC_IDX_W-1:0]  win_idx;
   logic                  win_found;
   logic                  out_free;
   logic                  out_load;

   // ------------------------------
   // Round-robin pick
   // ------------------------------
   always_comb begin
      int unsigned idx;
      win_found = 1'b0;
      win_idx   = ptr_q;
      // Search starts just after the last winner
      for (int k = 1; k <= NUM_CPL_SRC; k++) begin
         idx = (int'(ptr_q) + k) % NUM_CPL_SRC;
         if (!win_found && i_src_valid[idx]) begin
            win_found = 1'b1;
            win_idx   = SRC_IDX_W'(idx);
         end
      end
   end

   assign out_free = ~o_cpl_valid | i_cpl_ready;
   assign out_load = out_free & win_found;

   always_comb begin
      o_src_taken = '0;
      if (out_load)
         o_src_taken[win_idx] = 1'b1;
   end

   // Output register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_cpl_valid <= 1'b0;
         ptr_q       <= SRC_IDX_W'(NUM_CPL_SRC - 1);   // Source 0 goes first
      end else if (out_load) begin
         o_cpl_valid <= 1'b1;
         ptr_q       <= win_idx;
      end else if (i_cpl_ready) begin
         o_cpl_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (out_load)
         o_cpl <= i_src_cpl[win_idx];
   end

   a_taken_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(o_src_taken));

   a_cpl_stable: assert property (@(posedge clk) disable iff (!rst_n)
      o_cpl_valid && !i_cpl_ready |=> o_cpl_valid && $stable(o_cpl));

endmodule

/* hw/null_func.sv */
`timescale 1ns/100ps

module null_func #(
   parameter int USE_VIRTIO_GUID = 0   // 1 reports the virtio GUID
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mmio_pkg::mmio_req_t  i_req,
   input  logic                 i_deliver,
   output logic                 o_free,
   output mmio_pkg::mmio_cpl_t  o_cpl,
   output logic                 o_cpl_valid,
   input  logic                 i_cpl_taken
);
   import mmio_pkg::*;

   csr_data_t     scratch_q;
   logic [31:0]   debug_q;
   csr_data_t     reg_val;
   csr_data_t     rd_data;
   logic          is_mapped;
   logic          is_scratch;
   logic          upper_dw;    // 1-dword access to bits 63..32
   logic          wr_en;
   logic          rd_en;

   assign wr_en    = i_deliver &  i_req.wr;
   assign rd_en    = i_deliver & ~i_req.wr;
   assign upper_dw = ~i_req.len2 & i_req.addr[2];

   // ------------------------------
   // Register decode and read mux
   // ------------------------------
   always_comb begin
      is_mapped  = 1'b1;
      is_scratch = 1'b0;
      case (i_req.addr[11:3])
         DFH_ADDR[11:3]: begin
            reg_val = DFH_VALUE;
         end
         GUID_L_ADDR[11:3]: begin
            reg_val = (USE_VIRTIO_GUID != 0) ? VIRTIO_GUID_L : NULL_GUID_L;
         end
         GUID_H_ADDR[11:3]: begin
            reg_val = (USE_VIRTIO_GUID != 0) ? VIRTIO_GUID_H : NULL_GUID_H;
         end
         SCRATCH_ADDR[11:3]: begin
            reg_val    = scratch_q;
            is_scratch = 1'b1;
         end
         default: begin
            // Debug word on top, byte address below
            reg_val   = {debug_q, {(32 - ADDR_W){1'b0}}, i_req.addr};
            is_mapped = 1'b0;
         end
      endcase

      if (i_req.len2)
         rd_data = reg_val;
      else if (upper_dw)
         rd_data = {32'h0, reg_val[63:32]};
      else
         rd_data = {32'h0, reg_val[31:0]};
   end

   // ------------------------------
   // CSR writes
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         scratch_q <= '0;
         debug_q   <= DEBUG_RESET;
      end else if (wr_en) begin
         if (is_scratch) begin
            if (i_req.len2)
               scratch_q <= i_req.data;
            else if (upper_dw)
               scratch_q[63:32] <= i_req.data[31:0];
            else
               scratch_q[31:0] <= i_req.data[31:0];
         end else if (!is_mapped) begin
            debug_q <= DEBUG_STRAY;   // Stray write marker
         end
         // DFH and GUID are read only
      end
   end

   // Completion slot
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_cpl_valid <= 1'b0;
      end else if (rd_en) begin
         o_cpl_valid <= 1'b1;
      end else if (i_cpl_taken) begin
         o_cpl_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en)
         o_cpl <= make_cpl(i_req, CPL_SC, rd_data);
   end

   assign o_free = ~o_cpl_valid;

   // Router must hold requests while the slot is occupied
   a_no_deliver_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      i_deliver |-> !o_cpl_valid);

endmodule

/* hw/mmio_req_router.sv */
`timescale 1ns/100ps

module mmio_req_router (
   input  logic                            clk,
   input  logic                            rst_n,
   input  mmio_pkg::mmio_req_t             i_req,
   input  logic                            i_req_valid,
   output logic                            o_req_ready,
   input  logic [mmio_pkg::NUM_FUNCS-1:0]  i_func_free,
   output mmio_pkg::mmio_req_t             o_func_req,
   output logic [mmio_pkg::NUM_FUNCS-1:0]  o_func_deliver,
   output mmio_pkg::mmio_cpl_t             o_ur_cpl,
   output logic                            o_ur_valid,
   input  logic                            i_ur_taken
);
   import mmio_pkg::*;

   mmio_req_t              stage_q;
   logic                   stage_valid_q;
   logic                   stage_pop;
   logic                   fn_hit;        // Function number is implemented
   logic                   target_free;
   logic [NUM_FUNCS-1:0]   deliver_d;
   logic                   ur_deliver_d;
   logic                   ur_deliver_q;

   // ------------------------------
   // Target decode
   // ------------------------------
   always_comb begin
      fn_hit      = 1'b0;
      target_free = 1'b1;    // Stray writes just drain
      for (int i = 0; i < NUM_FUNCS; i++) begin
         if (stage_q.fn == fn_t'(i)) begin
            fn_hit = 1'b1;
            // A delivery in flight fills the slot on the next edge
            target_free = i_func_free[i] & ~o_func_deliver[i];
         end
      end
      if (!fn_hit && !stage_q.wr)
         target_free = ~o_ur_valid & ~ur_deliver_q;

      stage_pop = stage_valid_q & target_free;
      for (int i = 0; i < NUM_FUNCS; i++)
         deliver_d[i] = stage_pop & (stage_q.fn == fn_t'(i));
      ur_deliver_d = stage_pop & ~fn_hit & ~stage_q.wr;
   end

   assign o_req_ready = ~stage_valid_q | stage_pop;

   // Request stage
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stage_valid_q <= 1'b0;
      end else if (o_req_ready) begin
         stage_valid_q <= i_req_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (i_req_valid && o_req_ready)
         stage_q <= i_req;
      if (stage_pop)
         o_func_req <= stage_q;   // Shared bus to both functions and the UR slot
   end

   // ------------------------------
   // Delivery strobes and UR slot
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_func_deliver <= '0;
         ur_deliver_q   <= 1'b0;
         o_ur_valid     <= 1'b0;
      end else begin
         o_func_deliver <= deliver_d;
         ur_deliver_q   <= ur_deliver_d;
         if (ur_deliver_q)
            o_ur_valid <= 1'b1;
         else if (i_ur_taken)
            o_ur_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ur_deliver_q)
         o_ur_cpl <= make_cpl(o_func_req, CPL_UR, '0);   // Zero data on UR
   end

   a_deliver_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(o_func_deliver));

endmodule

/* hw/mmio_pkg.sv */
package mmio_pkg;

   // ------------------------------
   // Widths
   // ------------------------------
   localparam int ADDR_W      = 12;   // 4 KB window per function
   localparam int TAG_W       = 8;
   localparam int FN_W        = 2;
   localparam int REQ_ID_W    = 16;
   localparam int CSR_DATA_W  = 64;
   localparam int CPL_LEN_W   = 2;    // Length in dwords, 1 or 2
   localparam int LOW_ADDR_W  = 7;

   localparam int NUM_FUNCS   = 2;
   localparam int NUM_CPL_SRC = 3;    // Two functions plus the UR path
   localparam int UR_SRC      = 2;    // Arbiter input of the router
   localparam int SRC_IDX_W   = $clog2(NUM_CPL_SRC);

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [FN_W-1:0]       fn_t;
   typedef logic [REQ_ID_W-1:0]   req_id_t;
   typedef logic [CSR_DATA_W-1:0] csr_data_t;

   typedef enum logic [2:0] {
      CPL_SC = 3'b000,   // Successful completion
      CPL_UR = 3'b001    // Unsupported request
   } cpl_status_t;

   // A one-dword write carries its data in bits 31..0
   typedef struct packed {
      logic      wr;
      fn_t       fn;
      tag_t      tag;
      req_id_t   req_id;
      addr_t     addr;
      logic      len2;    // Set for a 2-dword access
      csr_data_t data;
   } mmio_req_t;

   typedef struct packed {
      fn_t                   fn;
      tag_t                  tag;
      req_id_t               req_id;
      cpl_status_t           status;
      logic [CPL_LEN_W-1:0]  len;
      logic [LOW_ADDR_W-1:0] low_addr;
      csr_data_t             data;
   } mmio_cpl_t;

   // ------------------------------
   // Register map, decoded on bits 11..3
   // ------------------------------
   localparam addr_t DFH_ADDR     = 12'h000;
   localparam addr_t GUID_L_ADDR  = 12'h008;
   localparam addr_t GUID_H_ADDR  = 12'h010;
   localparam addr_t SCRATCH_ADDR = 12'h018;

   // Type 1, end of list, id 0, version 0, no next header
   localparam csr_data_t DFH_VALUE = {4'h1, 19'h0, 1'b1, 24'h0, 4'h0, 12'h0};

   localparam csr_data_t VIRTIO_GUID_L = 64'hb9abefbd90b970c4;
   localparam csr_data_t VIRTIO_GUID_H = 64'h1aae155cacc54210;
   localparam csr_data_t NULL_GUID_L   = 64'haa31f54a3e403501;
   localparam csr_data_t NULL_GUID_H   = 64'h3e7b60a0df2d4850;

   localparam logic [31:0] DEBUG_RESET = 32'hdeadbeef;
   localparam logic [31:0] DEBUG_STRAY = 32'hbbbbbbbb;

   // Completion header taken from the request it answers
   function automatic mmio_cpl_t make_cpl(input mmio_req_t   req,
                                          input cpl_status_t status,
                                          input csr_data_t   data);
      mmio_cpl_t cpl;
      cpl.fn       = req.fn;
      cpl.tag      = req.tag;
      cpl.req_id   = req.req_id;
      cpl.status   = status;
      cpl.len      = req.len2 ? 2'd2 : 2'd1;
      cpl.low_addr = req.addr[LOW_ADDR_W-1:0];
      cpl.data     = data;
      return cpl;
   endfunction

endpackage
